//--- bench/adc_tests.txt
# columns: test name, 32-bit word in hex, hold flag
# hold 1 keeps word_ready low until the next word has replaced this one
ramp     01234567 0
ones     ffffffff 0
held_a   5a5a5a5a 1
alt_b    a5a5a5a5 0
zeros    00000000 0
top_bit  80000000 0
held_b   13579bdf 1
low_bit  00000001 0

//--- src.f
design/adc_pkg.sv
design/adc_sequencer.sv
design/adc_spi_engine.sv
design/adc_word_output.sv
design/adc_capture_top.sv
bench/adc_checker.sv
bench/adc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the ADC capture testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module adc_tb -Mdir "$build_dir" -f src.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$build_dir/Vadc_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -qx "test passed" "$log_file"; then
   exit 0
else
   echo "pass message not found in $log_file"
   exit 1
fi

//--- bench/adc_tb.sv
// adc_tb: testbench top with clock, reset, test file reader, ADC model, ready driver and watchdog
module adc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_tests  = 16;
   localparam int name_bits  = 8 * 16;
   localparam int clk_period = 100;
   localparam int msb        = adc_pkg::word_bits - 1;

   logic               capture_clk;
   logic               reset;
   logic               sdoa = 1'b0;
   logic               word_ready;
   adc_pkg::adc_pins_t pins;
   adc_pkg::adc_word_t word_data;
   logic               word_valid;
   logic               overrun;
   logic               sync_pin;
   logic               scka_pin;
   logic               mclk_pin;

   // test table filled from the data file
   adc_pkg::adc_word_t   test_word [max_tests];
   logic [name_bits-1:0] test_name [max_tests];
   logic                 hold_flag [max_tests];
   int                   num_tests;
   int                   tests_done;
   int                   error_count;

   // ADC model state, word_idx also counts the words already shifted out
   int   word_idx = 0;
   int   bit_idx = msb;
   logic model_configuring = 1'b1;
   int   seed = 32'h426b_cc76;

   assign sync_pin = pins.sync;
   assign scka_pin = pins.scka;
   assign mclk_pin = pins.mclk;

   adc_capture_top i_dut (
      .capture_clk (capture_clk),
      .reset       (reset),
      .sdoa        (sdoa),
      .word_ready  (word_ready),
      .pins        (pins),
      .word_data   (word_data),
      .word_valid  (word_valid),
      .overrun     (overrun)
   );

   adc_checker #(.max_tests(max_tests), .name_bits(name_bits)) i_checker (
      .capture_clk (capture_clk),
      .reset       (reset),
      .pins        (pins),
      .word_valid  (word_valid),
      .word_ready  (word_ready),
      .overrun     (overrun),
      .word_data   (word_data),
      .num_tests   (num_tests),
      .test_word   (test_word),
      .test_name   (test_name),
      .hold_flag   (hold_flag),
      .tests_done  (tests_done),
      .error_count (error_count)
   );

   // lines starting with # are comments, the rest hold name, hex word and hold flag
   task automatic read_tests;
      int                   fd;
      int                   n;
      int                   hold;
      string                line;
      logic [name_bits-1:0] name;
      logic [31:0]          value;
      num_tests = 0;
      fd = $fopen("bench/adc_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open bench/adc_tests.txt");
         return;
      end
      while (!$feof(fd) && num_tests < max_tests) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %h %d", name, value, hold);
            if (n == 3) begin
               test_name[num_tests] = name;
               test_word[num_tests] = value;
               hold_flag[num_tests] = (hold != 0);
               num_tests++;
            end
         end
      end
      $fclose(fd);
   endtask

   // every SDO bit handed to the DUT moves the model one bit down
   task automatic next_bit;
      if (bit_idx == 0) begin
         word_idx++;
         bit_idx = msb;
      end else begin
         bit_idx--;
      end
   endtask

   initial begin
      capture_clk = 1'b0;
      forever #(clk_period / 2) capture_clk = ~capture_clk;
   end

   // the sync pulse takes the MSB and each SCK falling edge the bits after it
   // edges before the first conversion belong to reset and configuration only
   always @(negedge sync_pin or negedge scka_pin or posedge mclk_pin or posedge reset) begin
      if (reset) begin
         bit_idx           = msb;
         model_configuring = 1'b1;
      end else if (mclk_pin) begin
         model_configuring = 1'b0;
      end else if (!model_configuring) begin
         next_bit();
      end
   end

   // SDO follows the model a little after each rising clock edge
   initial begin
      forever begin
         @(posedge capture_clk);
         #5;
         sdoa = (word_idx < num_tests) ? test_word[word_idx][bit_idx] : 1'b0;
      end
   end

   // ready goes low for a few cycles after each word so the new word is seen first,
   // and stays low through the next word after a held test
   initial begin
      int last_done;
      int settle;
      int low_run;
      int done_now;
      int rnd;
      last_done  = 0;
      settle     = 0;
      low_run    = 0;
      word_ready = 1'b0;
      forever begin
         @(posedge capture_clk);
         #5;
         done_now = word_idx;
         if (done_now != last_done) begin
            settle = 4;
         end else if (settle > 0) begin
            settle--;
         end
         last_done = done_now;
         if (settle > 0 || (done_now > 0 && done_now <= num_tests && hold_flag[done_now-1])) begin
            word_ready = 1'b0;
            low_run    = 0;
         end else if (low_run >= 3) begin
            word_ready = 1'b1;
            low_run    = 0;
         end else begin
            rnd        = $random(seed);
            word_ready = rnd[0];
            low_run    = rnd[0] ? 0 : low_run + 1;
         end
      end
   end

   initial begin
      reset = 1'b1;
      read_tests();
      if (num_tests == 0) begin
         $display("no tests were read from the data file");
         $display("test failed");
         $finish;
      end else begin
         repeat (16) @(posedge capture_clk);
         #5 reset = 1'b0;
         // a second reset halfway must bring configuration back and resume the data
         wait (tests_done >= num_tests / 2);
         @(posedge capture_clk);
         #5 reset = 1'b1;
         repeat (16) @(posedge capture_clk);
         #5 reset = 1'b0;
         wait (tests_done >= num_tests);
         repeat (4) @(posedge capture_clk);
         $display("tests run %0d of %0d, errors %0d", tests_done, num_tests, error_count);
         if (error_count == 0) begin
            $display("test passed");
         end else begin
            $display("test failed");
         end
         $finish;
      end
   end

   // a word takes eleven frames, twelve per test with a factor of two to spare
   initial begin
      wait (num_tests > 0);
      #(num_tests * 12 * adc_pkg::frame_cycles * clk_period * 2);
      $display("timeout: only %0d of %0d tests finished", tests_done, num_tests);
      $display("test failed");
      $finish;
   end

endmodule

//--- bench/adc_checker.sv
// adc_checker: watches the ADC pins and the word port and compares them with the test table
module adc_checker #(
   parameter int max_tests = 16,
   parameter int name_bits = 128
) (
   input  logic                 capture_clk,
   input  logic                 reset,
   input  adc_pkg::adc_pins_t   pins,
   input  logic                 word_valid,
   input  logic                 word_ready,
   input  logic                 overrun,
   input  adc_pkg::adc_word_t   word_data,
   input  int                   num_tests,
   input  adc_pkg::adc_word_t   test_word [max_tests],
   input  logic [name_bits-1:0] test_name [max_tests],
   input  logic                 hold_flag [max_tests],
   output int                   tests_done,
   output int                   error_count
);
   timeunit 1ns;
   timeprecision 100ps;

   // the ADC expects configure mode, no gain options, decimation by 16 and the flat filter
   localparam logic [1:0] cfg_mode       = 2'b10;
   localparam logic [1:0] cfg_gain       = 2'b00;
   localparam logic [3:0] cfg_decimation = 4'b0100;
   localparam logic [3:0] cfg_filter     = 4'b0110;
   localparam logic [adc_pkg::config_bits-1:0] expected_config =
      {cfg_mode, cfg_gain, cfg_decimation, cfg_filter};

   int   cycle = 0;
   int   errors = 0;
   int   next_test = 0;
   int   last_rise = 0;
   int   high_start = 0;
   int   config_count = 0;
   logic have_rise = 1'b0;
   logic in_pulse = 1'b0;
   logic configured = 1'b0;
   logic reset_d = 1'b0;
   logic reset_dd = 1'b0;
   logic prev_mclk = 1'b0;
   logic prev_scka = 1'b0;
   logic [adc_pkg::config_bits-1:0] config_seen = '0;

   assign tests_done  = next_test;
   assign error_count = errors;

   task automatic check_pins;
      // SDI is collected at every SCK rise until the first conversion
      if (pins.scka && !prev_scka && !configured) begin
         config_seen = {config_seen[adc_pkg::config_bits-2:0], pins.sdi};
         config_count++;
      end
      if (pins.mclk && !prev_mclk) begin
         if (!configured) begin
            configured = 1'b1;
            if (config_count != adc_pkg::config_bits) begin
               $display("configuration sent %0d sdi bits instead of %0d",
                        config_count, adc_pkg::config_bits);
               errors++;
            end else if (config_seen != expected_config) begin
               $display("mismatch configuration expected %h actual %h",
                        expected_config, config_seen);
               errors++;
            end else begin
               $display("configuration passed");
            end
         end
         if (have_rise && cycle - last_rise != adc_pkg::frame_cycles) begin
            $display("mclk rising edges %0d cycles apart instead of %0d",
                     cycle - last_rise, adc_pkg::frame_cycles);
            errors++;
         end
         have_rise  = 1'b1;
         last_rise  = cycle;
         in_pulse   = 1'b1;
         high_start = cycle;
      end
      if (!pins.mclk && prev_mclk && in_pulse) begin
         if (cycle - high_start != adc_pkg::convert_cycles) begin
            $display("mclk stayed high %0d cycles instead of %0d",
                     cycle - high_start, adc_pkg::convert_cycles);
            errors++;
         end
         in_pulse = 1'b0;
      end
   endtask

   // a held test ends when its replacement is taken, which also ends the next test
   task automatic check_word;
      if (next_test < num_tests && hold_flag[next_test]) begin
         if (!overrun) begin
            $display("%0s failed: overrun is low after the held word was replaced",
                     test_name[next_test]);
            errors++;
         end else if (word_data == test_word[next_test]) begin
            $display("%0s failed: the held word was delivered", test_name[next_test]);
            errors++;
         end else begin
            $display("%0s passed", test_name[next_test]);
         end
         next_test++;
      end
      if (next_test < num_tests) begin
         if (word_data !== test_word[next_test]) begin
            $display("mismatch %0s expected %h actual %h",
                     test_name[next_test], test_word[next_test], word_data);
            errors++;
         end else begin
            $display("%0s passed", test_name[next_test]);
         end
         next_test++;
      end
   endtask

   // values seen here are the ones registered at the previous edge
   always @(posedge capture_clk) begin
      cycle = cycle + 1;
      if ((reset_d || reset_dd) && (pins.mclk || pins.scka || word_valid || overrun)) begin
         $display("during or right after reset mclk, scka, word_valid or overrun was high");
         errors++;
      end
      // sync stays high for the whole reset state
      if ((reset_d || reset_dd) && !pins.sync) begin
         $display("sync was low during or right after reset");
         errors++;
      end
      if (reset) begin
         have_rise    = 1'b0;
         in_pulse     = 1'b0;
         configured   = 1'b0;
         config_count = 0;
      end else begin
         check_pins();
         if (word_valid && word_ready) check_word();
      end
      reset_dd  = reset_d;
      reset_d   = reset;
      prev_mclk = pins.mclk;
      prev_scka = pins.scka;
   end

endmodule

//--- design/adc_capture_top.sv
// adc_capture_top: ADC capture top level wiring sequencer, SPI engine and word output
module adc_capture_top (
   input  logic                capture_clk,
   input  logic                reset,
   input  logic                sdoa,
   input  logic                word_ready,
   output adc_pkg::adc_pins_t  pins,
   output adc_pkg::adc_word_t  word_data,
   output logic                word_valid,
   output logic                overrun
);

   adc_pkg::seq_ctrl_t ctrl;
   logic               config_done;
   logic               word_done;
   adc_pkg::adc_word_t word;

   adc_sequencer i_sequencer (
      .capture_clk (capture_clk),
      .reset       (reset),
      .config_done (config_done),
      .ctrl        (ctrl)
   );

   adc_spi_engine i_spi_engine (
      .capture_clk (capture_clk),
      .reset       (reset),
      .ctrl        (ctrl),
      .sdoa        (sdoa),
      .config_done (config_done),
      .pins        (pins),
      .word_done   (word_done),
      .word        (word)
   );

   adc_word_output i_word_output (
      .capture_clk (capture_clk),
      .reset       (reset),
      .word_done   (word_done),
      .word        (word),
      .word_ready  (word_ready),
      .word_valid  (word_valid),
      .word_data   (word_data),
      .overrun     (overrun)
   );

endmodule

//--- design/adc_word_output.sv
// adc_word_output: one-entry holding register with valid/ready and sticky overrun flag
module adc_word_output (
   input  logic                capture_clk,
   input  logic                reset,
   input  logic                word_done,
   input  adc_pkg::adc_word_t  word,
   input  logic                word_ready,
   output logic                word_valid,
   output adc_pkg::adc_word_t  word_data,
   output logic                overrun
);

   // the ADC cannot wait, so a new word always lands here
   always_ff @(posedge capture_clk) begin
      if (word_done) begin
         word_data <= word;
      end
   end

   always_ff @(posedge capture_clk) begin
      if (reset) begin
         word_valid <= 1'b0;
         overrun    <= 1'b0;
      end else begin
         if (word_done) begin
            word_valid <= 1'b1;
            // a held word that nobody took is lost, remember that until reset
            if (word_valid && !word_ready) overrun <= 1'b1;
         end else if (word_ready) begin
            word_valid <= 1'b0;
         end
      end
   end

   // a stalled word stays put and stays offered until a newer one arrives
   hold_stable: assert property (@(posedge capture_clk) disable iff (reset)
      word_valid && !word_ready && !word_done |=> word_valid && $stable(word_data));

endmodule

//--- design/adc_spi_engine.sv
// adc_spi_engine: configuration shifter, distributed-read capture shifter and registered ADC pins
module adc_spi_engine (
   input  logic                capture_clk,
   input  logic                reset,
   input  adc_pkg::seq_ctrl_t  ctrl,
   input  logic                sdoa,
   output logic                config_done,
   output adc_pkg::adc_pins_t  pins,
   output logic                word_done,
   output adc_pkg::adc_word_t  word
);

   logic is_config;
   logic is_sync;
   logic is_acquire;

   // configuration word, MSB on its way out first
   logic [adc_pkg::config_bits-1:0] config_shifter;
   // one-hot bit counter, the top bit marks the end of configuration
   logic [adc_pkg::config_bits:0]   config_count;
   logic                            config_shift;

   // next SDO bit to take, wraps to the top after bit 0
   logic [$clog2(adc_pkg::word_bits)-1:0] bit_pos;
   logic                                  capture_shift;
   logic                                  word_end;
   // armed between word completion and the next acquire window
   logic                                  sync_gate;

   assign is_config  = (ctrl.state == adc_pkg::st_config);
   assign is_sync    = (ctrl.state == adc_pkg::st_sync);
   assign is_acquire = (ctrl.state == adc_pkg::st_acquire);

   // a high SCK pin now means the edge at the end of this cycle is its falling edge
   assign config_shift = is_config && pins.scka;
   assign config_done  = config_count[adc_pkg::config_bits];

   // the SYNC pulse stands in for the first SCK since the MSB already sits on SDO
   assign capture_shift = (is_sync || is_acquire) && (pins.scka || pins.sync);
   assign word_end      = capture_shift && (bit_pos == '0);

   always_ff @(posedge capture_clk) begin
      if (!is_config) begin
         config_shifter <= adc_pkg::config_word;
         config_count   <= (adc_pkg::config_bits + 1)'(1);
      end else if (config_shift) begin
         config_shifter <= {config_shifter[adc_pkg::config_bits-2:0], 1'b0};
         config_count   <= {config_count[adc_pkg::config_bits-1:0], 1'b0};
      end
   end

   // the capture register keeps its bits across frames until the word is whole
   always_ff @(posedge capture_clk) begin
      if (capture_shift) begin
         word <= {word[adc_pkg::word_bits-2:0], sdoa};
      end
   end

   always_ff @(posedge capture_clk) begin
      if (reset) begin
         bit_pos   <= ($clog2(adc_pkg::word_bits))'(adc_pkg::word_bits - 1);
         word_done <= 1'b0;
         sync_gate <= 1'b1;
      end else begin
         if (capture_shift) bit_pos <= bit_pos - 1'b1;
         word_done <= word_end;
         // once the sync bit is in, bit_pos leaves the top and the gate may drop,
         // a word that ends mid-frame keeps the gate up until the next SYNC
         if (word_end) begin
            sync_gate <= 1'b1;
         end else if (is_acquire &&
                      bit_pos != ($clog2(adc_pkg::word_bits))'(adc_pkg::word_bits - 1)) begin
            sync_gate <= 1'b0;
         end
      end
   end

   // everything leaving for the ADC is registered so no pin can glitch
   always_ff @(posedge capture_clk) begin
      if (reset) begin
         pins <= '{mclk: 1'b0, scka: 1'b0, sync: 1'b1, sdi: 1'b0};
      end else begin
         // the start state keeps MCLK low in reset and during configuration
         pins.mclk <= (ctrl.state == adc_pkg::st_start) || (ctrl.state == adc_pkg::st_convert);
         // while the gate is up the pulse for the MSB is left out
         if ((is_acquire && !sync_gate) || (is_config && !config_done)) begin
            pins.scka <= ctrl.sck_phase;
         end else begin
            pins.scka <= 1'b0;
         end
         // the falling edge of SYNC realigns the decimation filter
         pins.sync <= (ctrl.state == adc_pkg::st_reset) || (is_sync && sync_gate && ctrl.sck_phase);
         // SDI moves together with the SCK falling edge so it is stable at the rise
         if (config_shift) begin
            pins.sdi <= config_shifter[adc_pkg::config_bits-2];
         end else if (is_config) begin
            pins.sdi <= config_shifter[adc_pkg::config_bits-1];
         end else begin
            pins.sdi <= 1'b0;
         end
      end
   end

   // the SPI bus must stay quiet while the ADC converts
   quiet_convert: assert property (@(posedge capture_clk) disable iff (reset)
      !(pins.mclk && pins.scka));

endmodule

//--- design/adc_sequencer.sv
// adc_sequencer: frame cycle counter and conversion state machine
module adc_sequencer (
   input  logic                capture_clk,
   input  logic                reset,
   input  logic                config_done,
   output adc_pkg::seq_ctrl_t  ctrl
);

   // free running position in the frame, the state lags it by one cycle
   adc_pkg::cycle_t     frame_cycle;
   adc_pkg::adc_state_t state;

   // window ends decoded from the counter
   logic convert_end;
   logic sync_end;
   logic acquire_end;
   logic wait_end;

   // the conversion occupies the start state plus the convert cycles after it
   assign convert_end = (frame_cycle == adc_pkg::cycle_t'(adc_pkg::convert_cycles - 1));

   // the SYNC window follows the conversion directly
   assign sync_end = (frame_cycle ==
      adc_pkg::cycle_t'(adc_pkg::convert_cycles + adc_pkg::sync_cycles - 1));

   // after the acquire window the frame is padded with wait cycles
   assign acquire_end = (frame_cycle == adc_pkg::cycle_t'(adc_pkg::convert_cycles
      + adc_pkg::sync_cycles + adc_pkg::acquire_cycles - 1));

   // last cycle of the frame, the next one is a start
   assign wait_end = (frame_cycle == adc_pkg::cycle_t'(adc_pkg::frame_cycles - 1));

   // the counter also runs during configuration since only its low bit is used there
   always_ff @(posedge capture_clk) begin
      if (reset || wait_end) begin
         frame_cycle <= '0;
      end else begin
         frame_cycle <= frame_cycle + 1'b1;
      end
   end

   always_ff @(posedge capture_clk) begin
      if (reset) begin
         state <= adc_pkg::st_reset;
      end else begin
         case (state)
            adc_pkg::st_reset: begin
               state <= adc_pkg::st_config;
            end
            // leaving through wait puts the first start on a frame boundary
            adc_pkg::st_config: begin
               if (config_done) state <= adc_pkg::st_wait;
            end
            adc_pkg::st_start: begin
               state <= adc_pkg::st_convert;
            end
            adc_pkg::st_convert: begin
               if (convert_end) state <= adc_pkg::st_sync;
            end
            adc_pkg::st_sync: begin
               if (sync_end) state <= adc_pkg::st_acquire;
            end
            adc_pkg::st_acquire: begin
               if (acquire_end) state <= adc_pkg::st_wait;
            end
            adc_pkg::st_wait: begin
               if (wait_end) state <= adc_pkg::st_start;
            end
            default: begin
               state <= adc_pkg::st_reset;
            end
         endcase
      end
   end

   // SCK is high on odd counts, so it may rise after an even cycle
   assign ctrl = '{state: state, sck_phase: ~frame_cycle[0]};

   // an illegal encoding would freeze the pins with no way out except reset
   state_legal: assert property (@(posedge capture_clk) disable iff (reset)
      state inside {adc_pkg::st_reset, adc_pkg::st_config, adc_pkg::st_start,
                    adc_pkg::st_convert, adc_pkg::st_sync, adc_pkg::st_acquire,
                    adc_pkg::st_wait});

endmodule

//--- design/adc_pkg.sv
// adc_pkg: frame timing constants, ADC configuration word, sequencer state type and structs
package adc_pkg;

   // capture_clk cycles in one conversion frame, SCK runs at half this clock so it must be even
   localparam int frame_cycles = 32;

   // cycles that MCLK stays high while the ADC converts, also even to keep the SCK phase
   localparam int convert_cycles = 22;

   // the SYNC window right after the conversion, one SCK period
   localparam int sync_cycles = 2;

   // acquire window, two cycles per SDO bit so three bits per frame
   localparam int acquire_cycles = 6;

   // width of the filtered ADC result
   localparam int word_bits = 32;

   // width of the configuration word shifted out on SDI
   localparam int config_bits = 12;

   // 10 selects configure mode, 00 leaves gain expansion and compression off,
   // 0100 is decimation by 16 and 0110 picks the flat filter
   localparam logic [config_bits-1:0] config_word = 12'b10_00_0100_0110;

   // position inside the frame, counts 0 to frame_cycles-1
   typedef logic [$clog2(frame_cycles)-1:0] cycle_t;

   // conversion state machine, one pass from start to wait per frame
   typedef enum logic [2:0] {
      st_reset,
      st_config,
      st_start,
      st_convert,
      st_sync,
      st_acquire,
      st_wait
   } adc_state_t;

   // what the sequencer tells the SPI engine on every cycle
   typedef struct packed {
      adc_state_t state;
      // high when the next clock edge may raise SCK
      logic       sck_phase;
   } seq_ctrl_t;

   // registered ADC pins
   typedef struct packed {
      logic mclk;
      logic scka;
      logic sync;
      logic sdi;
   } adc_pins_t;

   typedef logic [word_bits-1:0] adc_word_t;

endpackage
